// File: udp_tx_pkg.sv
package udp_tx_pkg;

    // ----------------------------------------
    // Station identity and fixed fields
    // ----------------------------------------
    localparam logic [47:0] board_mac   = 48'h00_11_22_33_44_55;
    localparam logic [31:0] board_ip    = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam logic [15:0] udp_port    = 16'd1234;   // Used as source and destination
    localparam logic [15:0] eth_type_ip = 16'h0800;

    localparam logic [7:0]  ip_ttl       = 8'h40;
    localparam logic [7:0]  ip_proto_udp = 8'd17;
    localparam logic [15:0] ip_flags_df  = 16'h4000;  // Don't fragment, offset 0

    // Sizes in bytes
    localparam logic [15:0] min_payload = 16'd18;     // 46 byte Ethernet minimum less 28
    localparam logic [15:0] max_payload = 16'd1472;
    localparam int ip_udp_hdr_bytes = 28;
    localparam int udp_hdr_bytes    = 8;
    localparam int preamble_bytes   = 8;
    localparam int eth_hdr_bytes    = 14;
    localparam int fcs_bytes        = 4;

    // Ethernet CRC-32, reflected form
    localparam logic [31:0] crc32_poly = 32'hEDB8_8320;
    localparam logic [31:0] crc32_init = 32'hFFFF_FFFF;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------
    localparam logic [7:0] addr_ctrl        = 8'h00;
    localparam logic [7:0] addr_status      = 8'h04;
    localparam logic [7:0] addr_dest_ip     = 8'h08;
    localparam logic [7:0] addr_dest_mac_hi = 8'h0C;
    localparam logic [7:0] addr_dest_mac_lo = 8'h10;
    localparam logic [7:0] addr_payload_len = 8'h14;

    // Everything the serializer needs for one frame
    typedef struct packed {
        logic [47:0]      dest_mac;
        logic [15:0]      payload_len;
        logic [6:0][31:0] ip_hdr;      // Word 0 goes on the wire first
    } frame_hdr_t;

    // One byte step of the CRC, LSB of the byte first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0])
                c = (c >> 1) ^ crc32_poly;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

// File: udp_tx_if.sv
`timescale 1ns/1ps

// Config handoff, fields hold while a frame is in flight
interface cfg_hdr_if;
    logic        start;
    logic [47:0] dest_mac;
    logic [31:0] dest_ip;
    logic [15:0] payload_len;

    modport src  (output start, dest_mac, dest_ip, payload_len);
    modport sink (input  start, dest_mac, dest_ip, payload_len);
endinterface

// Finished header, valid/ready
interface hdr_if;
    import udp_tx_pkg::*;

    logic       valid;
    logic       ready;
    frame_hdr_t hdr;

    modport src  (output valid, hdr, input  ready);
    modport sink (input  valid, hdr, output ready);
endinterface

// Byte stream toward GMII, no back-pressure
interface byte_if;
    logic       valid;
    logic [7:0] data;
    logic       crc_en;   // High for every byte after the SFD
    logic       last;     // Final padded payload byte

    modport src  (output valid, data, crc_en, last);
    modport sink (input  valid, data, crc_en, last);
endinterface

// File: udp_cfg_regs.sv
`timescale 1ns/1ps

module udp_cfg_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        tx_done,
    cfg_hdr_if.src      cfg
);
    import udp_tx_pkg::*;

    logic [47:0] dest_mac_q;
    logic [31:0] dest_ip_q;
    logic [15:0] len_q;
    logic        busy;
    logic        start_q;
    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic        start_accept;

    assign access       = psel & penable;   // APB access phase
    assign wr_en        = access & pwrite;
    assign start_accept = wr_en && (paddr == addr_ctrl) && pwdata[0] && !busy;

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dest_mac_q <= '0;
            dest_ip_q  <= '0;
            len_q      <= min_payload;
            busy       <= 1'b0;
            start_q    <= 1'b0;
        end else begin
            start_q <= start_accept;
            if (start_accept)
                busy <= 1'b1;
            else if (tx_done)
                busy <= 1'b0;

            // Fields frozen while a frame is going out
            if (wr_en && !busy) begin
                case (paddr)
                    addr_dest_ip:     dest_ip_q          <= pwdata;
                    addr_dest_mac_hi: dest_mac_q[47:32]  <= pwdata[15:0];
                    addr_dest_mac_lo: dest_mac_q[31:0]   <= pwdata;
                    addr_payload_len: begin
                        if (pwdata[15:0] != 16'd0 && pwdata[15:0] <= max_payload)
                            len_q <= pwdata[15:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read mux and address decode
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            addr_ctrl:        prdata = '0;   // Start is self clearing
            addr_status:      prdata = {31'd0, busy};
            addr_dest_ip:     prdata = dest_ip_q;
            addr_dest_mac_hi: prdata = {16'd0, dest_mac_q[47:32]};
            addr_dest_mac_lo: prdata = dest_mac_q[31:0];
            addr_payload_len: prdata = {16'd0, len_q};
            default:          addr_hit = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                  // Zero wait states
    assign pslverr = access & ~addr_hit;

    assign cfg.start       = start_q;
    assign cfg.dest_mac    = dest_mac_q;
    assign cfg.dest_ip     = dest_ip_q;
    assign cfg.payload_len = len_q;

endmodule

// File: ip_header_builder.sv
`timescale 1ns/1ps

module ip_header_builder (
    input  logic     clk,
    input  logic     rst_n,
    cfg_hdr_if.sink  cfg,
    hdr_if.src       hdr
);
    import udp_tx_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_sum,
        st_fold1,
        st_fold2,
        st_hold
    } state_t;

    state_t      state;
    logic [15:0] ident;
    frame_hdr_t  hdr_q;
    logic [31:0] csum;
    logic [19:0] hw_sum;
    logic [15:0] csum_fold;

    // Sum of the ten IP header halfwords, checksum field still zero
    always_comb begin
        hw_sum = '0;
        for (int i = 0; i < 5; i++) begin
            hw_sum = hw_sum + 20'(hdr_q.ip_hdr[i][31:16]) + 20'(hdr_q.ip_hdr[i][15:0]);
        end
    end

    assign csum_fold = csum[31:16] + csum[15:0];   // Second fold

    // ----------------------------------------
    // Sequencing, start to valid in four cycles
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ident <= 16'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (cfg.start) begin
                        state <= st_sum;
                        ident <= ident + 16'd1;
                    end
                end
                st_sum:   state <= st_fold1;
                st_fold1: state <= st_fold2;
                st_fold2: state <= st_hold;
                st_hold:  if (hdr.ready) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cfg.start) begin
            hdr_q.dest_mac    <= cfg.dest_mac;
            hdr_q.payload_len <= cfg.payload_len;
            hdr_q.ip_hdr[0]   <= {8'h45, 8'h00, cfg.payload_len + 16'(ip_udp_hdr_bytes)};
            hdr_q.ip_hdr[1]   <= {ident + 16'd1, ip_flags_df};
            hdr_q.ip_hdr[2]   <= {ip_ttl, ip_proto_udp, 16'h0000};
            hdr_q.ip_hdr[3]   <= board_ip;
            hdr_q.ip_hdr[4]   <= cfg.dest_ip;
            hdr_q.ip_hdr[5]   <= {udp_port, udp_port};
            hdr_q.ip_hdr[6]   <= {cfg.payload_len + 16'(udp_hdr_bytes), 16'h0000};
        end
        if (state == st_sum)
            csum <= {12'd0, hw_sum};
        if (state == st_fold1)
            csum <= {16'd0, csum[31:16]} + {16'd0, csum[15:0]};   // First fold
        if (state == st_fold2)
            hdr_q.ip_hdr[2][15:0] <= ~csum_fold;
    end

    assign hdr.valid = (state == st_hold);
    assign hdr.hdr   = hdr_q;

endmodule

// File: frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
    input  logic        clk,
    input  logic        rst_n,
    hdr_if.sink         hdr,
    output logic        word_req,
    input  logic [31:0] word_data,
    byte_if.src         bytes
);
    import udp_tx_pkg::*;

    typedef enum logic [2:0] {
        ph_idle,
        ph_pre,
        ph_eth,
        ph_ip,
        ph_pay
    } phase_t;

    phase_t                   phase;
    logic [15:0]              cnt;        // Byte index inside the current phase
    frame_hdr_t               hdr_q;
    logic [31:0]              word_q;
    logic [8*eth_hdr_bytes-1:0] eth_bytes;
    logic [15:0]              pay_total;
    logic [15:0]              last_cnt;
    logic                     at_end;
    logic [7:0]               byte_nxt;
    logic                     req_nxt;
    logic                     word_take;

    assign hdr.ready = (phase == ph_idle);
    assign eth_bytes = {hdr_q.dest_mac, board_mac, eth_type_ip};
    assign pay_total = (hdr_q.payload_len < min_payload) ? min_payload : hdr_q.payload_len;

    // Fresh word arrives on the first byte of each word
    assign word_take = (phase == ph_pay) && (cnt < hdr_q.payload_len) && (cnt[1:0] == 2'd0);

    always_comb begin
        case (phase)
            ph_pre:  last_cnt = 16'(preamble_bytes - 1);
            ph_eth:  last_cnt = 16'(eth_hdr_bytes - 1);
            ph_ip:   last_cnt = 16'(ip_udp_hdr_bytes - 1);
            default: last_cnt = pay_total - 16'd1;
        endcase
    end

    assign at_end = (cnt == last_cnt);

    // ----------------------------------------
    // Byte select per phase
    // ----------------------------------------
    always_comb begin
        byte_nxt = 8'h00;
        case (phase)
            ph_pre: byte_nxt = at_end ? 8'hd5 : 8'h55;      // SFD closes the preamble
            ph_eth: byte_nxt = eth_bytes[8 * (eth_hdr_bytes - 1 - int'(cnt[3:0])) +: 8];
            ph_ip:  byte_nxt = hdr_q.ip_hdr[cnt[4:2]][8 * (3 - int'(cnt[1:0])) +: 8];
            ph_pay: begin
                if (cnt >= hdr_q.payload_len)
                    byte_nxt = 8'h00;                       // Padding
                else if (word_take)
                    byte_nxt = word_data[7:0];
                else
                    byte_nxt = word_q[8 * cnt[1:0] +: 8];
            end
            default: byte_nxt = 8'h00;
        endcase
    end

    // Requests lead their first byte by two edges
    always_comb begin
        req_nxt = 1'b0;
        if (phase == ph_ip && cnt == 16'(ip_udp_hdr_bytes - 2))
            req_nxt = 1'b1;
        else if (phase == ph_pay && cnt[1:0] == 2'd2 && (cnt + 16'd2) < hdr_q.payload_len)
            req_nxt = 1'b1;
    end

    // ----------------------------------------
    // Phase machine and output register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= ph_idle;
            cnt          <= 16'd0;
            word_req     <= 1'b0;
            bytes.valid  <= 1'b0;
            bytes.data   <= 8'h00;
            bytes.crc_en <= 1'b0;
            bytes.last   <= 1'b0;
        end else begin
            word_req <= req_nxt;
            if (phase == ph_idle) begin
                bytes.valid  <= 1'b0;
                bytes.crc_en <= 1'b0;
                bytes.last   <= 1'b0;
                cnt          <= 16'd0;
                if (hdr.valid)
                    phase <= ph_pre;
            end else begin
                bytes.valid  <= 1'b1;
                bytes.data   <= byte_nxt;
                bytes.crc_en <= (phase != ph_pre);
                bytes.last   <= (phase == ph_pay) && at_end;
                if (at_end) begin
                    cnt <= 16'd0;
                    case (phase)
                        ph_pre:  phase <= ph_eth;
                        ph_eth:  phase <= ph_ip;
                        ph_ip:   phase <= ph_pay;
                        default: phase <= ph_idle;
                    endcase
                end else begin
                    cnt <= cnt + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr.valid && hdr.ready)
            hdr_q <= hdr.hdr;
        if (word_take)
            word_q <= word_data;   // Keep bytes 1 to 3
    end

endmodule

// File: fcs_appender.sv
`timescale 1ns/1ps

module fcs_appender (
    input  logic       clk,
    input  logic       rst_n,
    byte_if.sink       bytes,
    output logic       gmii_tx_en,
    output logic [7:0] gmii_txd,
    output logic       tx_done
);
    import udp_tx_pkg::*;

    logic [31:0] crc;
    logic        fcs_active;
    logic [1:0]  fcs_cnt;
    logic        fcs_end;      // Last FCS byte just went out
    logic        fcs_last;

    assign fcs_last = fcs_active && (fcs_cnt == 2'(fcs_bytes - 1));

    // ----------------------------------------
    // Stream register and CRC
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc        <= crc32_init;
            fcs_active <= 1'b0;
            fcs_cnt    <= 2'd0;
            fcs_end    <= 1'b0;
            tx_done    <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
        end else begin
            fcs_end <= fcs_last;
            tx_done <= fcs_end;
            if (bytes.valid) begin
                gmii_tx_en <= 1'b1;
                gmii_txd   <= bytes.data;
                if (bytes.crc_en)
                    crc <= crc32_byte(crc, bytes.data);
                if (bytes.last) begin
                    fcs_active <= 1'b1;
                    fcs_cnt    <= 2'd0;
                end
            end else if (fcs_active) begin
                gmii_tx_en <= 1'b1;
                gmii_txd   <= ~crc[8 * fcs_cnt +: 8];   // Low byte first
                fcs_cnt    <= fcs_cnt + 2'd1;
                if (fcs_last) begin
                    fcs_active <= 1'b0;
                    crc        <= crc32_init;         // Ready for the next frame
                end
            end else begin
                gmii_tx_en <= 1'b0;
                gmii_txd   <= 8'h00;
            end
        end
    end

endmodule

// File: udp_tx_top.sv
`timescale 1ns/1ps

module udp_tx_top (
    input  logic        clk,
    input  logic        rst_n,
    // APB slave
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // Payload fetch
    output logic        word_req,
    input  logic [31:0] word_data,
    // GMII transmit
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd,
    output logic        tx_done
);

    cfg_hdr_if u_cfg_if ();
    hdr_if     u_hdr_if ();
    byte_if    u_byte_if ();

    udp_cfg_regs i_cfg_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx_done (tx_done),
        .cfg     (u_cfg_if.src)
    );

    ip_header_builder i_hdr_builder (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (u_cfg_if.sink),
        .hdr   (u_hdr_if.src)
    );

    frame_serializer i_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr       (u_hdr_if.sink),
        .word_req  (word_req),
        .word_data (word_data),
        .bytes     (u_byte_if.src)
    );

    // FCS and GMII output stage
    fcs_appender i_fcs (
        .clk        (clk),
        .rst_n      (rst_n),
        .bytes      (u_byte_if.sink),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd),
        .tx_done    (tx_done)
    );

endmodule

// File: tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// ----------------------------------------
// Reference model of one frame on GMII
// ----------------------------------------

// Ones' complement sum of the IP header with the checksum field as zero
function automatic logic [15:0] ip_checksum(input logic [15:0] len, input logic [15:0] ident,
                                            input logic [31:0] dst_ip);
    logic [15:0] hw [10];
    logic [31:0] sum;
    hw = '{16'h4500, len + 16'd28, ident, 16'h4000, 16'h4011, 16'h0000,
           16'hc0a8, 16'h010a, dst_ip[31:16], dst_ip[15:0]};
    sum = 32'd0;
    foreach (hw[i])
        sum = sum + {16'd0, hw[i]};
    while (sum[31:16] != 16'd0)
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};   // End around carry
    return ~sum[15:0];
endfunction

// Bit serial CRC-32, LSB of each byte first
function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    c = crc_in;
    for (int k = 0; k < 8; k++) begin
        fb = c[0] ^ b[k];
        c  = {1'b0, c[31:1]};
        if (fb)
            c = c ^ 32'hedb8_8320;
    end
    return c;
endfunction

// Expected bytes from preamble to FCS, into exp_q
function automatic void build_frame(input logic [47:0] mac, input logic [31:0] dst_ip,
                                    input logic [15:0] len, input logic [15:0] ident);
    logic [111:0] eth;
    logic [223:0] ip_udp;
    logic [15:0]  pay_len;
    logic [31:0]  crc;
    eth     = {mac, 48'h0011_2233_4455, 16'h0800};
    ip_udp  = {16'h4500, len + 16'd28, ident, 16'h4000, 16'h4011,
               ip_checksum(len, ident, dst_ip), 32'hc0a8_010a, dst_ip,
               16'd1234, 16'd1234, len + 16'd8, 16'h0000};
    pay_len = (len < 16'd18) ? 16'd18 : len;
    exp_q.delete();
    repeat (7)
        exp_q.push_back(8'h55);
    exp_q.push_back(8'hd5);                                  // SFD
    for (int i = 13; i >= 0; i--)
        exp_q.push_back(eth[8 * i +: 8]);
    for (int i = 27; i >= 0; i--)
        exp_q.push_back(ip_udp[8 * i +: 8]);
    for (int i = 0; i < int'(pay_len); i++) begin
        if (i < int'(len))
            exp_q.push_back(word_log[word_base + i / 4][8 * (i % 4) +: 8]);
        else
            exp_q.push_back(8'h00);                          // Pad
    end
    crc = 32'hffff_ffff;
    for (int i = 8; i < exp_q.size(); i++)
        crc = crc_update(crc, exp_q[i]);
    crc = ~crc;
    for (int k = 0; k < 4; k++)
        exp_q.push_back(crc[8 * k +: 8]);
endfunction

`endif

// File: tb_udp_tx.sv
`timescale 1ns/1ps

module tb_udp_tx;
    import udp_tx_pkg::*;

    function automatic int wire_bytes(input int len);
        return 8 + 14 + 28 + ((len < 18) ? 18 : len) + 4;
    endfunction

    localparam int cycle_limit =
        4 * (wire_bytes(100) + wire_bytes(5) + wire_bytes(30) + wire_bytes(64) + 200);

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        word_req;
    logic [31:0] word_data = 32'h0;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;
    logic        tx_done;

    logic [7:0]  exp_q [$];
    logic [7:0]  rx_q [$];
    logic [31:0] word_log [$];      // Every word handed to the DUT
    int          word_base = 0;     // First word of the current frame
    logic [47:0] cur_mac;
    logic [31:0] cur_ip;
    logic [15:0] cur_len;
    logic [15:0] cur_ident = 16'd0;
    int          frames_seen = 0;
    int          cycles = 0;
    logic        prev_en = 1'b0;

    `include "tb_frame_model.svh"

    udp_tx_top i_udp_tx_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // APB master
    // ----------------------------------------
    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data,
                              output logic [31:0] rd, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        check_value("pready", 32'(pready), 32'd1);   // Zero wait states
        rd      = prdata;
        err     = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(addr, 1'b1, data, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic read_expect(input logic [7:0] addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(addr, 1'b0, 32'd0, rd, err);
        check_value(name, rd, exp);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    // Program, start and wait for one frame
    task automatic send_frame(input logic [47:0] mac, input logic [31:0] ip,
                              input logic [15:0] len, input bit extra_start);
        int target;
        target    = frames_seen + 1;
        cur_mac   = mac;
        cur_ip    = ip;
        cur_len   = len;
        cur_ident = cur_ident + 16'd1;
        word_base = word_log.size();
        apb_write(addr_dest_mac_hi, {16'd0, mac[47:32]});
        apb_write(addr_dest_mac_lo, mac[31:0]);
        apb_write(addr_dest_ip, ip);
        apb_write(addr_payload_len, {16'd0, len});
        apb_write(addr_ctrl, 32'd1);
        read_expect(addr_status, "status", 32'd1);
        if (extra_start) begin
            apb_write(addr_ctrl, 32'd1);                 // Ignored while busy
            read_expect(addr_status, "status", 32'd1);
        end
        while (frames_seen < target)
            @(posedge clk);
        read_expect(addr_status, "status", 32'd0);
    endtask

    task automatic compare_frame();
        build_frame(cur_mac, cur_ip, cur_len, cur_ident);
        check_value("frame_length", 32'(rx_q.size()), 32'(exp_q.size()));
        check_value("ip_ident", {16'd0, rx_q[26], rx_q[27]}, {16'd0, cur_ident});
        for (int i = 0; i < exp_q.size(); i++)
            check_value($sformatf("gmii_txd[%0d]", i), 32'(rx_q[i]), 32'(exp_q[i]));
        check_value("word_req_count", 32'(word_log.size() - word_base),
                    32'((int'(cur_len) + 3) / 4));
    endtask

    // Payload source for every word request
    always @(posedge clk) begin : respond
        logic [31:0] w;
        if (word_req) begin
            w = $urandom;
            word_data <= w;
            word_log.push_back(w);
        end
    end

    // GMII monitor and frame compare
    always @(posedge clk) begin
        if (rst_n) begin
            check_value("tx_done", 32'(tx_done), 32'(prev_en && !gmii_tx_en));
            if (gmii_tx_en)
                rx_q.push_back(gmii_txd);
            if (prev_en && !gmii_tx_en) begin
                compare_frame();
                rx_q.delete();
                frames_seen <= frames_seen + 1;
            end
            prev_en <= gmii_tx_en;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: frames not finished after %0d cycles", cycles);
            abort_run();
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        void'($urandom(32'haacac039));
        rst_n   <= 1'b0;
        paddr   <= 8'h00;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= 32'h0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        check_value("gmii_tx_en", 32'(gmii_tx_en), 32'd0);
        check_value("word_req", 32'(word_req), 32'd0);
        check_value("pslverr", 32'(pslverr), 32'd0);

        // Register readback
        apb_write(addr_dest_ip, 32'h0a00_0102);
        apb_write(addr_dest_mac_hi, 32'h0000_a1b2);
        apb_write(addr_dest_mac_lo, 32'hc3d4_e5f6);
        apb_write(addr_payload_len, 32'd100);
        read_expect(addr_dest_ip, "dest_ip", 32'h0a00_0102);
        read_expect(addr_dest_mac_hi, "dest_mac_hi", 32'h0000_a1b2);
        read_expect(addr_dest_mac_lo, "dest_mac_lo", 32'hc3d4_e5f6);
        read_expect(addr_payload_len, "payload_len", 32'd100);
        read_expect(addr_status, "status", 32'd0);

        apb_access(8'h18, 1'b0, 32'd0, rd, err);      // Unmapped offset
        check_value("pslverr", 32'(err), 32'd1);

        // ----------------------------------------
        // Frames
        // ----------------------------------------
        send_frame(48'ha1b2_c3d4_e5f6, 32'h0a00_0102, 16'd100, 1'b0);
        send_frame(48'h0203_0405_0607, 32'hc0a8_0114, 16'd5, 1'b0);   // Padded
        send_frame(48'hffee_ddcc_bbaa, 32'h0a0b_0c0d, 16'd30, 1'b1);
        repeat (100) @(posedge clk);
        check_value("frame_count", 32'(frames_seen), 32'd3);
        send_frame(48'h1234_5678_9abc, 32'h7f00_0001, 16'd64, 1'b0);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
udp_tx_pkg.sv
udp_tx_if.sv
udp_cfg_regs.sv
ip_header_builder.sv
frame_serializer.sv
fcs_appender.sv
udp_tx_top.sv
tb_udp_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UDP transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_udp_tx -f src.f -o tb_udp_tx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_udp_tx > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
else
    exit 1
fi
